// ==== all.f ====
verilog/sigdecode_h_pkg.sv
verilog/sdh_hint_if.sv
verilog/sigdecode_h_ctrl.sv
verilog/sigdecode_h_bitmap.sv
verilog/sigdecode_h_check.sv
verilog/sigdecode_h_top.sv
testbench/sigdecode_h_properties.sv
testbench/tb_sigdecode_h.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sigdecode_h
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/tb_sigdecode_h.sv ====
/*
  Directed testbench for the hint decoder top level.
  Models the register array (one-cycle dword answer, combinational hint sum)
  and records every memory write. Expected words come from a reference
  decoder working on the encoded hint. Stops at the first mismatch.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_sigdecode_h
    import sigdecode_h_pkg::*;
();

    localparam int MLDSA_N         = MLDSA_N_DEF;
    localparam int MLDSA_K         = MLDSA_K_DEF;
    localparam int WORDS           = MLDSA_N / 4;
    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 16;
    // Worst case run with every polynomial written plus some read overhead each
    localparam int RUN_CYCLES      = MLDSA_K * (WORDS + 8);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 6 * RUN_CYCLES + 200;

    logic        clk            = 1'b0;
    logic        reset_n        = 1'b0;
    logic        zeroize        = 1'b0;
    logic        enable         = 1'b0;
    mem_addr_t   dest_base_addr = '0;
    hint_dword_t hint_data      = '0;
    hint_byte_t  hintsum;
    logic        done;
    logic        error;
    logic        hint_rd_en;
    rd_ptr_t     rd_ptr;
    poly_idx_t   hintsum_sel;
    logic        mem_wr_en;
    mem_addr_t   mem_wr_addr;
    mem_word_t   mem_wr_data;

    // Encoded hint as index bytes followed by one cumulative sum per polynomial
    hint_byte_t  idx_mem [0:131] = '{default: '0};
    hint_byte_t  sum_mem [0:15]  = '{default: '0};

    mem_addr_t   wr_addr_q [$];
    mem_word_t   wr_data_q [$];
    logic [15:0] lfsr_state = 16'd34605;
    int          num_checks = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sigdecode_h_top #(
        .MLDSA_N (MLDSA_N),
        .MLDSA_K (MLDSA_K)
    ) i_dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .dest_base_addr (dest_base_addr),
        .done           (done),
        .error          (error),
        .hint_rd_en     (hint_rd_en),
        .rd_ptr         (rd_ptr),
        .hint_data      (hint_data),
        .hintsum_sel    (hintsum_sel),
        .hintsum        (hintsum),
        .mem_wr_en      (mem_wr_en),
        .mem_wr_addr    (mem_wr_addr),
        .mem_wr_data    (mem_wr_data)
    );

    // ----------------------------------------
    // Register array and memory models
    // ----------------------------------------
    assign hintsum = sum_mem[hintsum_sel];

    always @(posedge clk) begin
        if (hint_rd_en) begin
            hint_data <= {idx_mem[int'(rd_ptr) + 3], idx_mem[int'(rd_ptr) + 2],
                          idx_mem[int'(rd_ptr) + 1], idx_mem[int'(rd_ptr)]};
        end
    end

    always @(posedge clk) begin
        if (mem_wr_en) begin
            wr_addr_q.push_back(mem_wr_addr);
            wr_data_q.push_back(mem_wr_data);
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic fail_run(string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(string name, mem_word_t expected, mem_word_t actual);
        num_checks++;
        if (expected !== actual) begin
            fail_run($sformatf("[FAIL] %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic int next_random_bits(int nbits);
        int   value;
        logic out_bit;
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) lfsr_state = lfsr_state ^ 16'hB400;
            value = (value << 1) | int'(out_bit);
        end
        return value;
    endfunction

    task automatic clear_encoding();
        for (int i = 0; i < 132; i++) begin
            idx_mem[i] = '0;
        end
        for (int p = 0; p < 16; p++) begin
            sum_mem[p] = '0;
        end
    endtask

    task automatic set_sums(int s0, int s1, int rest);
        sum_mem[0] = hint_byte_t'(s0);
        sum_mem[1] = hint_byte_t'(s1);
        for (int p = 2; p < MLDSA_K; p++) begin
            sum_mem[p] = hint_byte_t'(rest);
        end
    endtask

    // Ascending index bytes from one position to the end of the index area
    task automatic fill_ascending(int first);
        for (int k = first; k < 132; k++) begin
            idx_mem[k] = hint_byte_t'(k - first);
        end
    endtask

    // Random sorted distinct indices with polynomials 1 and 5 left empty
    task automatic fill_random(int total);
        int                 remaining;
        int                 count;
        int                 pos;
        logic [MLDSA_N-1:0] pick;
        clear_encoding();
        remaining = total;
        pos       = 0;
        for (int p = 0; p < MLDSA_K; p++) begin
            if (p == 1 || p == 5) begin
                count = 0;
            end else if (p == MLDSA_K - 1) begin
                count = remaining;
            end else begin
                count = next_random_bits(5);
                if (count > remaining) count = remaining;
            end
            pick = '0;
            while ($countones(pick) < count) begin
                pick[next_random_bits($clog2(MLDSA_N))] = 1'b1;
            end
            for (int c = 0; c < MLDSA_N; c++) begin
                if (pick[c]) begin
                    idx_mem[pos] = hint_byte_t'(c);
                    pos++;
                end
            end
            remaining -= count;
            sum_mem[p] = hint_byte_t'(pos);
        end
    endtask

    // Reference decoder for one memory word of one polynomial
    function automatic mem_word_t expected_word(int poly, int word);
        int        lo;
        int        hi;
        int        idx;
        mem_word_t w;
        w  = '0;
        lo = (poly == 0) ? 0 : int'(sum_mem[poly - 1]);
        hi = int'(sum_mem[poly]);
        for (int k = lo; k < hi; k++) begin
            idx = int'(idx_mem[k]);
            if (idx / 4 == word) w[(idx % 4) * COEFF_W] = 1'b1;
        end
        return w;
    endfunction

    task automatic start_run(mem_addr_t base);
        wr_addr_q.delete();
        wr_data_q.delete();
        @(posedge clk);
        dest_base_addr <= base;
        enable         <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
    endtask

    task automatic wait_done(string name);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!done) begin
            if (cycles >= 2 * RUN_CYCLES) begin
                fail_run($sformatf("%s: timed out waiting for done", name));
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic wait_writes(string name, int count);
        int cycles;
        cycles = 0;
        while (wr_addr_q.size() < count) begin
            if (cycles >= 2 * RUN_CYCLES) begin
                fail_run($sformatf("%s: timed out waiting for %0d writes", name, count));
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic check_writes(string name, mem_addr_t base, int npolys);
        int        total;
        mem_addr_t addr;
        total = npolys * WORDS;
        check_value({name, " write count"}, mem_word_t'(total), mem_word_t'(wr_addr_q.size()));
        for (int i = 0; i < total; i++) begin
            addr = base + mem_addr_t'(i);
            check_value($sformatf("%s address %0d", name, i),
                        mem_word_t'(addr), mem_word_t'(wr_addr_q[i]));
            check_value($sformatf("%s data %0d", name, i),
                        expected_word(i / WORDS, i % WORDS), wr_data_q[i]);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_all_zero();
        clear_encoding();
        start_run(14'h0100);
        wait_done("all_zero");
        check_writes("all_zero", 14'h0100, MLDSA_K);
        check_value("all_zero error", '0, mem_word_t'(error));
    endtask

    task automatic test_random_valid();
        fill_random(OMEGA);
        start_run(14'h1200);
        wait_done("random_valid");
        check_writes("random_valid", 14'h1200, MLDSA_K);
        check_value("random_valid error", '0, mem_word_t'(error));
    endtask

    task automatic test_sum_over_omega();
        clear_encoding();
        idx_mem[0] = 8'd5;
        idx_mem[1] = 8'd77;
        idx_mem[2] = 8'd0;
        idx_mem[3] = 8'd1;
        idx_mem[4] = 8'd2;
        idx_mem[5] = 8'd3;
        idx_mem[6] = 8'd4;
        idx_mem[7] = 8'd200;
        // Bytes past polynomial 1 keep ascending so only the sum rule is broken
        fill_ascending(8);
        set_sums(2, 8, OMEGA + 15);
        start_run(14'h0400);
        wait_done("sum_over_omega");
        check_value("sum_over_omega error", mem_word_t'(1), mem_word_t'(error));
        // Polynomials 0 and 1 complete before the bad sum is latched
        check_writes("sum_over_omega", 14'h0400, 2);
    endtask

    task automatic test_decreasing_sums();
        clear_encoding();
        idx_mem[0] = 8'd10;
        idx_mem[1] = 8'd20;
        idx_mem[2] = 8'd30;
        idx_mem[3] = 8'd1;
        idx_mem[4] = 8'd2;
        idx_mem[5] = 8'd3;
        idx_mem[6] = 8'd4;
        fill_ascending(7);
        set_sums(3, 7, 4);
        start_run(14'h0400);
        wait_done("decreasing_sums");
        check_value("decreasing_sums error", mem_word_t'(1), mem_word_t'(error));
        check_writes("decreasing_sums", 14'h0400, 2);
    endtask

    task automatic test_bad_indices();
        // Repeated index inside polynomial 1
        clear_encoding();
        idx_mem[0] = 8'd3;
        idx_mem[1] = 8'd9;
        idx_mem[2] = 8'd40;
        idx_mem[3] = 8'd40;
        idx_mem[4] = 8'd50;
        set_sums(2, 5, 5);
        start_run(14'h0000);
        wait_done("repeated_index");
        check_value("repeated_index error", mem_word_t'(1), mem_word_t'(error));

        fill_random(OMEGA);
        start_run(14'h0600);
        wait_done("after_error");
        check_value("after_error error", '0, mem_word_t'(error));
        check_writes("after_error", 14'h0600, MLDSA_K);

        // Drop across a dword boundary
        clear_encoding();
        idx_mem[0] = 8'd1;
        idx_mem[1] = 8'd2;
        idx_mem[2] = 8'd3;
        idx_mem[3] = 8'd4;
        idx_mem[4] = 8'd0;
        set_sums(5, 5, 5);
        start_run(14'h0000);
        wait_done("decreasing_index");
        check_value("decreasing_index error", mem_word_t'(1), mem_word_t'(error));
    endtask

    task automatic test_zeroize_mid_run();
        int count;
        fill_random(OMEGA);
        start_run(14'h0800);
        wait_writes("zeroize", 100);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        @(posedge clk);
        check_value("zeroize done", mem_word_t'(1), mem_word_t'(done));
        count = wr_addr_q.size();
        repeat (20) @(posedge clk);
        check_value("zeroize writes stopped", mem_word_t'(count),
                    mem_word_t'(wr_addr_q.size()));
        check_value("zeroize still done", mem_word_t'(1), mem_word_t'(done));

        fill_random(OMEGA);
        start_run(14'h2000);
        wait_done("after_zeroize");
        check_writes("after_zeroize", 14'h2000, MLDSA_K);
        check_value("after_zeroize error", '0, mem_word_t'(error));
    endtask

    // ----------------------------------------
    // Sequence and watchdog
    // ----------------------------------------
    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        check_value("idle done", mem_word_t'(1), mem_word_t'(done));
        test_all_zero();
        test_random_valid();
        test_sum_over_omega();
        test_decreasing_sums();
        test_bad_indices();
        test_zeroize_mid_run();
        if (num_checks > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run("No checks were performed");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Watchdog expired before all tests finished");
    end

endmodule

`default_nettype wire

// ==== testbench/sigdecode_h_properties.sv ====
/*
  Concurrent checks bound into the hint decoder top level.
  Writes of one polynomial are expected on consecutive cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module sigdecode_h_properties
    import sigdecode_h_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input logic      done,
    input logic      error,
    input logic      hint_rd_en,
    input logic      mem_wr_en,
    input mem_addr_t mem_wr_addr
);

    // No traffic while idle
    idle_quiet: assert property (
        @(posedge clk) disable iff (!reset_n)
        done |-> (!mem_wr_en && !hint_rd_en)
    ) else $error("read or write strobe while done is high");

    // Back to back writes walk the address up by one
    addr_step: assert property (
        @(posedge clk) disable iff (!reset_n)
        (mem_wr_en && $past(mem_wr_en)) |-> (mem_wr_addr == $past(mem_wr_addr) + mem_addr_t'(1))
    ) else $error("write address did not advance by one");

    // Abort reaches idle right after the error is raised
    error_abort: assert property (
        @(posedge clk) disable iff (!reset_n)
        $rose(error) |=> done
    ) else $error("done did not follow error");

endmodule

bind sigdecode_h_top sigdecode_h_properties i_properties (
    .clk         (clk),
    .reset_n     (reset_n),
    .done        (done),
    .error       (error),
    .hint_rd_en  (hint_rd_en),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr)
);

`default_nettype wire

// ==== verilog/sigdecode_h_top.sv ====
/*
  Hint decoder top level.
  Reads answer one cycle after hint_rd_en; hintsum is combinational
  from hintsum_sel. Memory writes have no back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

module sigdecode_h_top
    import sigdecode_h_pkg::*;
#(
    parameter int MLDSA_N = MLDSA_N_DEF,
    parameter int MLDSA_K = MLDSA_K_DEF
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize,
    input  logic        enable,
    input  mem_addr_t   dest_base_addr,
    output logic        done,
    output logic        error,

    // Register array read port
    output logic        hint_rd_en,
    output rd_ptr_t     rd_ptr,
    input  hint_dword_t hint_data,

    // Hint sum byte of the selected polynomial
    output poly_idx_t   hintsum_sel,
    input  hint_byte_t  hintsum,

    // Memory write port
    output logic        mem_wr_en,
    output mem_addr_t   mem_wr_addr,
    output mem_word_t   mem_wr_data
);

    sdh_hint_if #(.MLDSA_N(MLDSA_N)) hint_bus ();

    sigdecode_h_ctrl #(
        .MLDSA_N (MLDSA_N),
        .MLDSA_K (MLDSA_K)
    ) u_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .dest_base_addr (dest_base_addr),
        .hintsum        (hintsum),
        .error          (error),
        .hintsum_sel    (hintsum_sel),
        .hint_rd_en     (hint_rd_en),
        .rd_ptr         (rd_ptr),
        .mem_wr_en      (mem_wr_en),
        .mem_wr_addr    (mem_wr_addr),
        .done           (done),
        .hint           (hint_bus.ctrl)
    );

    sigdecode_h_bitmap #(
        .MLDSA_N (MLDSA_N)
    ) u_bitmap (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .hint_data   (hint_data),
        .mem_wr_data (mem_wr_data),
        .hint        (hint_bus.sink)
    );

    sigdecode_h_check u_check (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .enable    (enable),
        .hintsum   (hintsum),
        .hint_data (hint_data),
        .error     (error),
        .hint      (hint_bus.sink)
    );

endmodule

`default_nettype wire

// ==== verilog/sigdecode_h_check.sv ====
/*
  Encoding checks on the hint sums and index bytes.
  The error is sticky until the next enable or zeroize.
  A violation shows on error one cycle after it is seen.
*/
`timescale 1ns/1ps
`default_nettype none

module sigdecode_h_check
    import sigdecode_h_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize,
    input  logic        enable,
    input  hint_byte_t  hintsum,
    input  hint_dword_t hint_data,
    output logic        error,
    sdh_hint_if.sink    hint
);

    hint_byte_t prev_sum;
    hint_byte_t last_idx;
    hint_byte_t prior;
    logic       have_last;
    logic       prior_ok;
    logic       sum_err;
    logic       idx_err;

    // Hint sums never decrease and never pass OMEGA
    assign sum_err = hint.hintsum_latch &&
                     ((hintsum > hint_byte_t'(OMEGA)) || (hintsum < prev_sum));

    // Enabled bytes must climb strictly, starting from the last index seen
    always_comb begin
        idx_err  = 1'b0;
        prior    = last_idx;
        prior_ok = have_last;
        if (hint.map_valid) begin
            for (int j = 0; j < 4; j++) begin
                if (hint.curr_poly_map[j]) begin
                    if (prior_ok && (hint_data[8*j +: 8] <= prior)) idx_err = 1'b1;
                    prior    = hint_data[8*j +: 8];
                    prior_ok = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prev_sum <= '0;
            error    <= 1'b0;
        end else if (zeroize || enable) begin
            prev_sum <= '0;
            error    <= 1'b0;
        end else begin
            if (hint.hintsum_latch) prev_sum <= hintsum;
            if (sum_err || idx_err) error <= 1'b1;
        end
    end

    // Last index of the current polynomial
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_idx  <= '0;
            have_last <= 1'b0;
        end else if (zeroize || hint.hintsum_latch) begin
            last_idx  <= '0;
            have_last <= 1'b0;
        end else if (hint.map_valid) begin
            last_idx  <= prior;
            have_last <= prior_ok;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sigdecode_h_bitmap.sv ====
/*
  Hint bitmap of one polynomial, filled from index bytes.
  Index bytes are taken modulo MLDSA_N, exact for MLDSA_N = 256.
  The output word also sees the dword arriving in the same cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module sigdecode_h_bitmap
    import sigdecode_h_pkg::*;
#(
    parameter int MLDSA_N = MLDSA_N_DEF
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize,
    input  hint_dword_t hint_data,
    output mem_word_t   mem_wr_data,
    sdh_hint_if.sink    hint
);

    localparam int PTR_W = $clog2(MLDSA_N);

    logic [MLDSA_N-1:0] bitmap;
    logic [MLDSA_N-1:0] fill;
    logic [MLDSA_N-1:0] merged;
    logic [PTR_W-1:0]   coeff_idx;

    // Bits set by the bytes of the current answer
    always_comb begin
        fill = '0;
        if (hint.map_valid) begin
            for (int j = 0; j < 4; j++) begin
                if (hint.curr_poly_map[j]) begin
                    fill[hint_data[8*j +: PTR_W]] = 1'b1;
                end
            end
        end
        merged = bitmap | fill;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bitmap <= '0;
        end else if (zeroize || hint.rst_bitmap) begin
            bitmap <= '0;
        end else begin
            bitmap <= merged;
        end
    end

    // Four coefficients starting at bitmap_ptr, zero extended
    always_comb begin
        coeff_idx   = '0;
        mem_wr_data = '0;
        for (int c = 0; c < 4; c++) begin
            coeff_idx = hint.bitmap_ptr | PTR_W'(c);
            mem_wr_data[c*COEFF_W +: COEFF_W] = COEFF_W'(merged[coeff_idx]);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sigdecode_h_ctrl.sv ====
/*
  Read and write sequencing for hint decoding.
  Assumes the read side of a polynomial finishes before its 64 word writes,
  which holds for MLDSA_N = 256 since at most OMEGA/4 + 1 requests are made.
  An error sends both FSMs to idle in the next cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module sigdecode_h_ctrl
    import sigdecode_h_pkg::*;
#(
    parameter int MLDSA_N = MLDSA_N_DEF,
    parameter int MLDSA_K = MLDSA_K_DEF
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize,
    input  logic       enable,
    input  mem_addr_t  dest_base_addr,
    input  hint_byte_t hintsum,
    input  logic       error,
    output poly_idx_t  hintsum_sel,
    output logic       hint_rd_en,
    output rd_ptr_t    rd_ptr,
    output logic       mem_wr_en,
    output mem_addr_t  mem_wr_addr,
    output logic       done,
    sdh_hint_if.ctrl   hint
);

    localparam int PTR_W = $clog2(MLDSA_N);

    sdh_read_state_e  rd_state, rd_state_nxt;
    sdh_write_state_e wr_state, wr_state_nxt;

    poly_idx_t        poly_cnt;
    hint_byte_t       rem_hints;
    hint_byte_t       prev_sum;
    hint_byte_t       rd_step;
    mem_addr_t        wr_addr;
    logic [PTR_W-1:0] word_ptr;
    logic [3:0]       tail_map;
    logic [3:0]       map_q;
    logic             map_valid_q;
    logic             start;
    logic             latch_sum;
    logic             rd_req;
    logic             poly_done_rd;
    logic             last_poly;
    logic             last_word;
    logic             wr_go;
    logic             rst_bitmap;

    // Status and shared strobes
    assign done         = (rd_state == RD_IDLE) && (wr_state == WR_IDLE);
    assign start        = enable && done;
    assign last_poly    = (poly_cnt == poly_idx_t'(MLDSA_K - 1));
    assign last_word    = (word_ptr == PTR_W'(MLDSA_N - 4));
    assign latch_sum    = (rd_state == RD_HINTSUM);
    assign poly_done_rd = (rd_state == RD_EXEC) && (rem_hints == '0);
    assign rd_req       = (rd_state == RD_EXEC) && !error && (rem_hints != '0);
    assign wr_go        = (wr_state == WR_MEM) && !error;

    // Bytes consumed by one request, and which of them belong to this polynomial
    always_comb begin
        rd_step  = (rem_hints >= 8'd4) ? 8'd4 : rem_hints;
        tail_map = 4'b1111;
        case (rem_hints)
            8'd1:    tail_map = 4'b0001;
            8'd2:    tail_map = 4'b0011;
            8'd3:    tail_map = 4'b0111;
            default: tail_map = 4'b1111;
        endcase
    end

    // ----------------------------------------
    // Read FSM
    // ----------------------------------------
    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            RD_IDLE: begin
                if (start) rd_state_nxt = RD_INIT;
            end
            RD_INIT: begin
                // Wait until the previous polynomial is fully written
                if (error) begin
                    rd_state_nxt = RD_IDLE;
                end else if (wr_state == WR_INIT) begin
                    rd_state_nxt = RD_HINTSUM;
                end
            end
            RD_HINTSUM: begin
                rd_state_nxt = error ? RD_IDLE : RD_EXEC;
            end
            RD_EXEC: begin
                if (error) begin
                    rd_state_nxt = RD_IDLE;
                end else if (rem_hints == '0) begin
                    rd_state_nxt = last_poly ? RD_IDLE : RD_INIT;
                end
            end
            default: rd_state_nxt = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state    <= RD_IDLE;
            rem_hints   <= '0;
            prev_sum    <= '0;
            rd_ptr      <= '0;
            map_valid_q <= 1'b0;
            map_q       <= '0;
        end else if (zeroize) begin
            rd_state    <= RD_IDLE;
            rem_hints   <= '0;
            prev_sum    <= '0;
            rd_ptr      <= '0;
            map_valid_q <= 1'b0;
            map_q       <= '0;
        end else begin
            rd_state    <= rd_state_nxt;
            map_valid_q <= rd_req;
            map_q       <= rd_req ? tail_map : 4'b0000;
            if (start) begin
                rem_hints <= '0;
                prev_sum  <= '0;
                rd_ptr    <= '0;
            end else if (latch_sum) begin
                // Own count is the step from the previous cumulative sum
                rem_hints <= hintsum - prev_sum;
                prev_sum  <= hintsum;
            end else if (rd_req) begin
                rem_hints <= rem_hints - rd_step;
                rd_ptr    <= rd_ptr + rd_ptr_t'(rd_step);
            end
        end
    end

    // ----------------------------------------
    // Write FSM
    // ----------------------------------------
    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            WR_IDLE: begin
                if (start) wr_state_nxt = WR_INIT;
            end
            WR_INIT: begin
                // First answer seen, or nothing to read for this polynomial
                if (error) begin
                    wr_state_nxt = WR_IDLE;
                end else if (map_valid_q || poly_done_rd) begin
                    wr_state_nxt = WR_MEM;
                end
            end
            WR_MEM: begin
                if (error) begin
                    wr_state_nxt = WR_IDLE;
                end else if (last_word) begin
                    wr_state_nxt = last_poly ? WR_IDLE : WR_INIT;
                end
            end
            default: wr_state_nxt = WR_IDLE;
        endcase
    end

    // Clear on the last word, and on abort so no stale bits survive
    assign rst_bitmap = ((wr_state == WR_INIT) && error) ||
                        ((wr_state == WR_MEM) && (error || last_word));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state <= WR_IDLE;
            wr_addr  <= '0;
            word_ptr <= '0;
            poly_cnt <= '0;
        end else if (zeroize) begin
            wr_state <= WR_IDLE;
            wr_addr  <= '0;
            word_ptr <= '0;
            poly_cnt <= '0;
        end else begin
            wr_state <= wr_state_nxt;
            if (wr_state == WR_IDLE) begin
                wr_addr  <= dest_base_addr;
                word_ptr <= '0;
                if (start) poly_cnt <= '0;
            end else if (wr_go) begin
                wr_addr  <= wr_addr + mem_addr_t'(1);
                word_ptr <= last_word ? '0 : word_ptr + PTR_W'(4);
                if (last_word) begin
                    poly_cnt <= last_poly ? '0 : poly_cnt + poly_idx_t'(1);
                end
            end
        end
    end

    // Outputs
    assign hintsum_sel        = poly_cnt;
    assign hint_rd_en         = rd_req;
    assign mem_wr_en          = wr_go;
    assign mem_wr_addr        = wr_addr;
    assign hint.hintsum_latch = latch_sum;
    assign hint.map_valid     = map_valid_q;
    assign hint.curr_poly_map = map_q;
    assign hint.rst_bitmap    = rst_bitmap;
    assign hint.bitmap_ptr    = word_ptr;

endmodule

`default_nettype wire

// ==== verilog/sdh_hint_if.sv ====
/*
  Bitmap control from the controller to the bitmap and the checker.
  All signals are driven by the controller and are valid per cycle.
*/
`timescale 1ns/1ps
`default_nettype none

interface sdh_hint_if
    import sigdecode_h_pkg::*;
#(
    parameter int MLDSA_N = MLDSA_N_DEF
);

    logic                       hintsum_latch;  // Hint sum sampled this cycle
    logic                       map_valid;      // hint_data answers a request
    logic [3:0]                 curr_poly_map;  // Bytes of hint_data in this polynomial
    logic                       rst_bitmap;
    logic [$clog2(MLDSA_N)-1:0] bitmap_ptr;     // First coefficient of the word written

    modport ctrl (
        output hintsum_latch, map_valid, curr_poly_map, rst_bitmap, bitmap_ptr
    );

    modport sink (
        input hintsum_latch, map_valid, curr_poly_map, rst_bitmap, bitmap_ptr
    );

endinterface

`default_nettype wire

// ==== verilog/sigdecode_h_pkg.sv ====
/*
  Shared definitions for the ML-DSA hint decoder.
  OMEGA is fixed by the signature encoding and is not a parameter.
  Memory words hold four coefficients, coefficient 0 in the low bits.
*/
`default_nettype none

package sigdecode_h_pkg;

    // Default sizes, overridden from the top level
    localparam int MLDSA_N_DEF = 256;
    localparam int MLDSA_K_DEF = 8;

    // Maximum total hint count over all polynomials
    localparam int OMEGA = 75;

    localparam int MEM_ADDR_W = 14;
    localparam int COEFF_W    = 24;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [7:0]            hint_byte_t;
    typedef logic [31:0]           hint_dword_t;   // byte 0 at lowest address
    typedef logic [6:0]            rd_ptr_t;
    typedef logic [3:0]            poly_idx_t;
    typedef logic [4*COEFF_W-1:0]  mem_word_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_INIT,
        RD_HINTSUM,
        RD_EXEC
    } sdh_read_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_INIT,
        WR_MEM
    } sdh_write_state_e;

endpackage

`default_nettype wire
